// ==== sim.f ====
logic/scopePkg.sv
logic/rasterIf.sv
logic/vgaTiming.sv
logic/sampleBuffer.sv
logic/waveShader.sv
logic/audioScope.sv
sim/audioScope_sva.sv
sim/audioScopeTb.sv

// ==== Makefile ====
TOP = audioScopeTb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)
	verilator --lint-only logic/scopePkg.sv logic/rasterIf.sv logic/vgaTiming.sv \
		logic/sampleBuffer.sv logic/waveShader.sv logic/audioScope.sv --top-module audioScope

clean:
	rm -rf obj_dir

// ==== sim/audioScopeTb.sv ====
`timescale 1ns/100ps

module audioScopeTb import scopePkg::*; ();

  bit         clk;
  logic       rstN;
  logic       sampleValid;
  sample_u    sampleLeft;
  sample_u    sampleRight;
  mode_t      modeDrv;
  logic [7:0] vgaR;
  logic [7:0] vgaG;
  logic [7:0] vgaB;
  logic       vgaHs;
  logic       vgaVs;
  logic       vgaBlankN;
  rgb_t       outPix;       // Output colour as one word
  rgb_t       expPix;

  sample_u refLeft  [numCols]; // Model of buffer contents
  sample_u refRight [numCols];
  int      refPtr;             // Model write pointer

  int   xPos;          // Tracked from output levels only
  int   yPos;
  int   lineCycles;    // Cycles since last hs fall
  int   lineCnt;       // Lines since last vs fall
  int   activeLines;
  int   framesChecked; // Whole frames compared
  int   litPixels;     // Trace or axis pixels seen
  logic prevHs;
  logic prevVs;
  logic prevBlankN;
  logic hsSeen;
  logic vsSeen;

  audioScope u_audioScope (
    .clk         (clk),
    .rstN        (rstN),
    .sampleValid (sampleValid),
    .sampleLeft  (sampleLeft),
    .sampleRight (sampleRight),
    .mode        (modeDrv),
    .vgaR        (vgaR),
    .vgaG        (vgaG),
    .vgaB        (vgaB),
    .vgaHs       (vgaHs),
    .vgaVs       (vgaVs),
    .vgaBlankN   (vgaBlankN)
  );

  assign outPix = {vgaR, vgaG, vgaB};

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "Run stopped");
  endtask

  task automatic checkPixel(input string name, input int x, input int y,
                            input rgb_t got, input rgb_t want);
    if (got !== want) abortRun($sformatf("Error %s at x=%0d y=%0d got 0x%06h expected 0x%06h",
                                         name, x, y, got, want));
  endtask

  task automatic checkLevel(input string name, input logic got, input logic want);
    if (got !== want) abortRun($sformatf("Error %s got 0x%0h expected 0x%0h", name, got, want));
  endtask

  task automatic matchCount(input string name, input int got, input int want);
    if (got != want) abortRun($sformatf("Error %s got 0x%0h expected 0x%0h", name, got, want));
  endtask

  // Both traces win over one trace, which wins over the axis
  function automatic rgb_t expectPixel(input int col, input int row, input mode_t m);
    int   rowL;
    int   rowR;
    logic hitL;
    logic hitR;
    rowL = axisRow - int'(refLeft[col].pos.row); // Positive amplitude above axis
    rowR = axisRow - int'(refRight[col].pos.row);
    hitL = m.showLeft && (row == rowL);          // Off screen rows never match
    hitR = m.showRight && (row == rowR);
    if (hitL && hitR) return colBoth;
    if (hitL) return colLeft;
    if (hitR) return colRight;
    if (m.showAxis && (row == axisRow)) return colAxis;
    return colBlack;
  endfunction

  task automatic waitVs(input logic level);
    int cnt;
    cnt = 0;
    @(negedge clk);
    while ((vgaVs !== level) && (cnt < hTotal * vTotal + hTotal)) begin // About one frame
      @(negedge clk);
      cnt++;
    end
    if (vgaVs !== level) abortRun("Timed out waiting for the vertical sync level");
  endtask

  task automatic writePair(input sample_u l, input sample_u r);
    @(posedge clk);
    sampleValid <= 1'b1;
    sampleLeft  <= l;
    sampleRight <= r;
    refLeft[refPtr]  = l;
    refRight[refPtr] = r;
    refPtr = (refPtr + 1) % numCols; // Same wrap as the buffer
  endtask

  task automatic closeBurst(input mode_t m);
    @(posedge clk);
    sampleValid <= 1'b0;
    modeDrv     <= m; // Still inside vertical sync
  endtask

  task automatic showFrame();
    waitVs(1'b1);
    waitVs(1'b0); // Next frame now fully drawn
  endtask

  // Bound checker failures end the run
  always @(u_audioScope.u_audioScopeSva.assertFails) begin
    if (u_audioScope.u_audioScopeSva.assertFails != 0) begin
      abortRun("An assertion in the bound checker failed");
    end
  end

  // Outputs sampled on the falling edge while stable
  always @(negedge clk) begin
    if (!rstN) begin
      checkLevel("vgaHs", vgaHs, 1'b1);
      checkLevel("vgaVs", vgaVs, 1'b1);
      checkPixel("vgaRGB in reset", 0, 0, outPix, colBlack);
      xPos = 0;
      yPos = 0;
      lineCycles = 0;
      lineCnt = 0;
      activeLines = 0;
      framesChecked = 0;
      litPixels = 0;
      prevHs = 1'b1;
      prevVs = 1'b1;
      prevBlankN = 1'b0;
      hsSeen = 1'b0;
      vsSeen = 1'b0;
    end else begin
      if (prevHs && !vgaHs) begin // Line boundary
        if (hsSeen) matchCount("cycles per line", lineCycles, hTotal);
        hsSeen = 1'b1;
        lineCycles = 0;
        lineCnt++;
      end
      lineCycles++;
      if (prevVs && !vgaVs) begin // Frame boundary
        if (vsSeen) begin // First frame after reset is partial
          matchCount("lines per frame", lineCnt, vTotal);
          matchCount("active lines per frame", activeLines, vActive);
          framesChecked++;
        end
        vsSeen = 1'b1;
        lineCnt = 0;
        activeLines = 0;
        yPos = 0;
      end
      if (vgaBlankN) begin
        if ((xPos >= hActive) || (yPos >= vActive)) abortRun("Visible pixel outside 640x480");
        expPix = expectPixel(xPos / colWidth, yPos, modeDrv);
        if (expPix != colBlack) litPixels++;
        checkPixel("vgaRGB", xPos, yPos, outPix, expPix);
        xPos++;
      end else begin
        checkPixel("vgaRGB in blanking", xPos, yPos, outPix, colBlack);
        if (prevBlankN) begin // End of visible line
          matchCount("pixels per line", xPos, hActive);
          xPos = 0;
          yPos++;
          activeLines++;
        end
      end
      prevHs = vgaHs;
      prevVs = vgaVs;
      prevBlankN = vgaBlankN;
    end
  end

  initial begin
    sample_u     l;
    sample_u     r;
    logic [15:0] base;
    logic [15:0] step;
    int          i;
    void'($urandom(32'h7cf7ac17));
    rstN = 1'b0;
    sampleValid = 1'b0;
    sampleLeft = '0;
    sampleRight = '0;
    modeDrv = '0;  // First frame is all black
    refPtr = 0;
    for (i = 0; i < numCols; i++) begin
      refLeft[i] = '0;
      refRight[i] = '0;
    end
    repeat (10) @(posedge clk);
    rstN <= 1'b1;
    waitVs(1'b0);

    base = 16'($urandom); // Random ramp on the left trace
    step = 16'($urandom_range(511, 64));
    for (i = 0; i < numCols; i++) begin
      l.amp = base + step * 16'(i);
      r.amp = 16'($urandom);
      writePair(l, r);
    end
    closeBurst('{showLeft: 1'b1, showRight: 1'b0, showAxis: 1'b0});
    showFrame();

    for (i = 0; i < numCols; i++) begin // Every third stereo column coincides
      l.amp = 16'($urandom);
      r.amp = (i % 3 == 0) ? l.amp : 16'($urandom);
      writePair(l, r);
    end
    closeBurst('{showLeft: 1'b1, showRight: 1'b1, showAxis: 1'b0});
    showFrame();

    for (i = 0; i < numCols; i++) begin // Rows just off and just on screen
      case (i % 4)
        0: begin
          l.amp = 16'h7FFF; // Row -15
          r.amp = 16'h8000; // Row 496
        end
        1: begin
          l.amp = 16'h7880; // Row -1
          r.amp = 16'h8800; // Row 480
        end
        2: begin
          l.amp = 16'h7800; // Row 0
          r.amp = 16'h8880; // Row 479
        end
        default: begin
          l.amp = 16'($urandom);
          r.amp = 16'($urandom);
        end
      endcase
      writePair(l, r);
    end
    closeBurst('{showLeft: 1'b1, showRight: 1'b1, showAxis: 1'b1});
    showFrame();

    for (i = 0; i < numCols + 40; i++) begin // 200 writes wrap the pointer to 40
      l.amp = 16'($urandom);
      r.amp = 16'($urandom);
      writePair(l, r);
    end
    closeBurst('{showLeft: 1'b1, showRight: 1'b1, showAxis: 1'b1});
    showFrame();

    @(negedge clk);
    if ((framesChecked < 4) || (litPixels == 0)) begin
      abortRun("Too few frames or no lit pixels were compared");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

// ==== sim/audioScope_sva.sv ====
`timescale 1ns/100ps

module audioScopeSva import scopePkg::*; (
  input logic       clk,
  input logic       rstN,
  input logic [7:0] vgaR,
  input logic [7:0] vgaG,
  input logic [7:0] vgaB,
  input logic       vgaHs,
  input logic       vgaVs,
  input logic       vgaBlankN
);

  int   hsLowCnt;    // Consecutive low samples of vgaHs
  logic inReset;     // Reset applied at previous edge
  int   assertFails; // Failed assertions so far

  always_ff @(posedge clk) begin
    inReset <= !rstN;
    if (!rstN || vgaHs) begin
      hsLowCnt <= 0;
    end else begin
      hsLowCnt <= hsLowCnt + 1;
    end
  end

  // Width known once sync returns high
  hsWidth: assert property (@(posedge clk) disable iff (!rstN)
    $rose(vgaHs) |-> (hsLowCnt == hSync))
    else begin
      assertFails++;
      $error("vgaHs low for %0d cycles", hsLowCnt);
    end

  blankBlack: assert property (@(posedge clk)
    !vgaBlankN |-> ({vgaR, vgaG, vgaB} == 24'h0))
    else begin
      assertFails++;
      $error("Colour not black while blanked");
    end

  resetSync: assert property (@(posedge clk)
    (inReset && !rstN) |-> (vgaHs && vgaVs))
    else begin
      assertFails++;
      $error("Sync active during reset");
    end

endmodule

bind audioScope audioScopeSva u_audioScopeSva (
  .clk       (clk),
  .rstN      (rstN),
  .vgaR      (vgaR),
  .vgaG      (vgaG),
  .vgaB      (vgaB),
  .vgaHs     (vgaHs),
  .vgaVs     (vgaVs),
  .vgaBlankN (vgaBlankN)
);

// ==== logic/audioScope.sv ====
`timescale 1ns/100ps

module audioScope import scopePkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic        sampleValid, // Strobe, one pair per pulse
  input  logic [15:0] sampleLeft,
  input  logic [15:0] sampleRight,
  input  logic [2:0]  mode,        // Left, right, axis enables
  output logic [7:0]  vgaR,
  output logic [7:0]  vgaG,
  output logic [7:0]  vgaB,
  output logic        vgaHs,
  output logic        vgaVs,
  output logic        vgaBlankN
);

  rasterIf raster ();  // Timing to shader

  colIdx_t rdCol;      // Shader column request
  sample_u rdLeft;     // Buffer read data
  sample_u rdRight;
  rgb_t    pixel;      // Shaded colour, 2 cycles behind raster

  vgaTiming u_vgaTiming (
    .clk    (clk),
    .rstN   (rstN),
    .raster (raster.gen)
  );

  sampleBuffer u_sampleBuffer (
    .clk         (clk),
    .rstN        (rstN),
    .sampleValid (sampleValid),
    .sampleLeft  (sampleLeft),
    .sampleRight (sampleRight),
    .rdCol       (rdCol),
    .rdLeft      (rdLeft),
    .rdRight     (rdRight)
  );

  waveShader u_waveShader (
    .clk       (clk),
    .rstN      (rstN),
    .raster    (raster.user),
    .mode      (mode),
    .rdCol     (rdCol),
    .rdLeft    (rdLeft),
    .rdRight   (rdRight),
    .pixel     (pixel),
    .vgaHs     (vgaHs),
    .vgaVs     (vgaVs),
    .vgaBlankN (vgaBlankN)
  );

  assign vgaR = pixel.r; // Split for DAC pins
  assign vgaG = pixel.g;
  assign vgaB = pixel.b;

endmodule

// ==== logic/waveShader.sv ====
`timescale 1ns/100ps

module waveShader import scopePkg::*; (
  input  logic    clk,
  input  logic    rstN,
  rasterIf.user   raster,
  input  mode_t   mode,      // Trace and axis enables
  output colIdx_t rdCol,     // Buffer column for current x
  input  sample_u rdLeft,    // Arrives one cycle after rdCol
  input  sample_u rdRight,
  output rgb_t    pixel,
  output logic    vgaHs,
  output logic    vgaVs,
  output logic    vgaBlankN
);

  // Stage 1, alongside the buffer read
  yCoord_t yD1;
  logic    activeD1;
  logic    hsD1;
  logic    vsD1;

  logic signed [10:0] rowLeft;  // Screen row of left trace
  logic signed [10:0] rowRight; // Screen row of right trace
  logic signed [10:0] rowY;     // Current row, widened for signed compare
  logic               hitLeft;
  logic               hitRight;
  logic               onAxis;
  rgb_t               colour;

  assign rdCol = colIdx_t'(raster.x / colWidth); // 4 pixels share one column

  always_ff @(posedge clk) begin
    if (!rstN) begin
      activeD1 <= 1'b0;
      hsD1     <= 1'b1;
      vsD1     <= 1'b1;
    end else begin
      activeD1 <= raster.active;
      hsD1     <= raster.hs;
      vsD1     <= raster.vs;
    end
  end

  always_ff @(posedge clk) begin
    yD1 <= raster.y; // Payload, follows the read
  end

  // Positive amplitude draws above the axis
  assign rowLeft  = 11'(axisRow) - 11'(signed'(rdLeft.pos.row));
  assign rowRight = 11'(axisRow) - 11'(signed'(rdRight.pos.row));
  assign rowY     = signed'({1'b0, yD1});

  assign hitLeft  = mode.showLeft && (rowY == rowLeft);   // Off screen rows never match
  assign hitRight = mode.showRight && (rowY == rowRight);
  assign onAxis   = mode.showAxis && (yD1 == yCoord_t'(axisRow));

  // Colour priority, traces over axis
  always_comb begin
    if (!activeD1) begin
      colour = colBlack; // Blanking
    end else if (hitLeft && hitRight) begin
      colour = colBoth;
    end else if (hitLeft) begin
      colour = colLeft;
    end else if (hitRight) begin
      colour = colRight;
    end else if (onAxis) begin
      colour = colAxis;
    end else begin
      colour = colBlack;
    end
  end

  // Stage 2, colour register with matching sync delay
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pixel     <= colBlack;
      vgaHs     <= 1'b1;
      vgaVs     <= 1'b1;
      vgaBlankN <= 1'b0;
    end else begin
      pixel     <= colour;
      vgaHs     <= hsD1;
      vgaVs     <= vsD1;
      vgaBlankN <= activeD1;
    end
  end

endmodule

// ==== logic/sampleBuffer.sv ====
`timescale 1ns/100ps

module sampleBuffer import scopePkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  logic    sampleValid, // One cycle strobe per stereo pair
  input  sample_u sampleLeft,
  input  sample_u sampleRight,
  input  colIdx_t rdCol,       // Column requested by shader
  output sample_u rdLeft,      // Valid one cycle after rdCol
  output sample_u rdRight
);

  sample_u memLeft  [numCols]; // Left channel columns
  sample_u memRight [numCols]; // Right channel columns
  colIdx_t wrPtr;              // Next column to overwrite
  logic    rdInRange;

  assign rdInRange = (rdCol < colIdx_t'(numCols)); // Blanking columns run past 159

  // Write pointer wraps at numCols, no back-pressure
  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr <= '0;
    end else if (sampleValid) begin
      if (wrPtr == colIdx_t'(numCols - 1)) begin
        wrPtr <= '0;
      end else begin
        wrPtr <= wrPtr + 1'b1;
      end
    end
  end

  // Storage, contents survive reset
  always_ff @(posedge clk) begin
    if (sampleValid) begin
      memLeft[wrPtr]  <= sampleLeft;
      memRight[wrPtr] <= sampleRight;
    end
  end

  // Registered read port
  always_ff @(posedge clk) begin
    if (rdInRange) begin
      rdLeft  <= memLeft[rdCol];
      rdRight <= memRight[rdCol];
    end
  end

endmodule

// ==== logic/vgaTiming.sv ====
`timescale 1ns/100ps

module vgaTiming import scopePkg::*; (
  input  logic   clk,
  input  logic   rstN,
  rasterIf.gen   raster
);

  xCoord_t hCnt;     // Pixel counter within line
  yCoord_t vCnt;     // Line counter within frame
  xCoord_t hNext;
  yCoord_t vNext;
  logic    hsNext;
  logic    vsNext;
  logic    activeNext;
  logic    hsReg;
  logic    vsReg;
  logic    activeReg;

  // Next raster position
  always_comb begin
    hNext = hCnt + 1'b1;
    vNext = vCnt;
    if (hCnt == xCoord_t'(hTotal - 1)) begin // End of line
      hNext = '0;
      if (vCnt == yCoord_t'(vTotal - 1)) begin // End of frame
        vNext = '0;
      end else begin
        vNext = vCnt + 1'b1;
      end
    end
  end

  // Levels decoded from the next position so they line up with the counters
  always_comb begin
    hsNext = !((hNext >= xCoord_t'(hActive + hFront)) &&
               (hNext <  xCoord_t'(hActive + hFront + hSync))); // Low in sync window
    vsNext = !((vNext >= yCoord_t'(vActive + vFront)) &&
               (vNext <  yCoord_t'(vActive + vFront + vSync)));
    activeNext = (hNext < xCoord_t'(hActive)) && (vNext < yCoord_t'(vActive));
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      hCnt      <= '0;   // Park at top left
      vCnt      <= '0;
      hsReg     <= 1'b1; // Syncs idle high
      vsReg     <= 1'b1;
      activeReg <= 1'b1; // Position 0,0 is visible
    end else begin
      hCnt      <= hNext;
      vCnt      <= vNext;
      hsReg     <= hsNext;
      vsReg     <= vsNext;
      activeReg <= activeNext;
    end
  end

  assign raster.x      = hCnt;
  assign raster.y      = vCnt;
  assign raster.hs     = hsReg;
  assign raster.vs     = vsReg;
  assign raster.active = activeReg;

endmodule

// ==== logic/rasterIf.sv ====
`timescale 1ns/100ps

interface rasterIf import scopePkg::*; ();

  xCoord_t x;      // Current column
  yCoord_t y;      // Current row
  logic    active; // Inside 640x480 window
  logic    hs;     // Horizontal sync, active low
  logic    vs;     // Vertical sync, active low

  modport gen (
    output x,
    output y,
    output active,
    output hs,
    output vs
  );

  // Shader side, read only
  modport user (
    input x,
    input y,
    input active,
    input hs,
    input vs
  );

endinterface

// ==== logic/scopePkg.sv ====
package scopePkg;

  // 640x480 raster, counts in pixel clocks
  localparam int hActive = 640; // Visible pixels per line
  localparam int hFront  = 16;  // Front porch
  localparam int hSync   = 96;  // Sync pulse width
  localparam int hBack   = 48;  // Back porch
  localparam int hTotal  = hActive + hFront + hSync + hBack; // 800 clocks per line

  localparam int vActive = 480; // Visible lines
  localparam int vFront  = 10;
  localparam int vSync   = 2;
  localparam int vBack   = 33;
  localparam int vTotal  = vActive + vFront + vSync + vBack; // 525 lines per frame

  localparam int colWidth = 4;   // Screen pixels per stored column
  localparam int numCols  = 160; // hActive / colWidth
  localparam int axisRow  = 240; // Zero amplitude line, mid screen

  typedef logic [9:0] xCoord_t; // Covers 0..799
  typedef logic [9:0] yCoord_t; // Covers 0..524
  typedef logic [7:0] colIdx_t; // Covers x / colWidth over the whole line

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  localparam rgb_t colLeft  = '{r: 8'h00, g: 8'hFF, b: 8'h00}; // Green
  localparam rgb_t colRight = '{r: 8'hFF, g: 8'h00, b: 8'h00}; // Red
  localparam rgb_t colBoth  = '{r: 8'hFF, g: 8'hFF, b: 8'h00}; // Yellow, traces coincide
  localparam rgb_t colAxis  = '{r: 8'h40, g: 8'h40, b: 8'h40}; // Dim grey
  localparam rgb_t colBlack = '0;

  // One audio word, seen as amplitude or as screen row plus fraction
  typedef union packed {
    logic signed [15:0] amp; // Raw codec sample
    struct packed {
      logic signed [8:0] row;  // Upper bits, row offset above the axis
      logic [6:0]        frac; // Dropped by the display
    } pos;
  } sample_u;

  typedef struct packed {
    logic showLeft;  // Bit 2
    logic showRight; // Bit 1
    logic showAxis;  // Bit 0
  } mode_t;

endpackage
